// File: mem_pkg.sv
/*
 * shared definitions for the tagged data memory
 * sizes, latency and tag pool constants
 * bus command and access size encodings
 * request and return structs
 */

`default_nettype none

package mem_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // sizes
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN              = 32;
    localparam int LINE_W            = 64;
    localparam int MEM_64BIT_LINES   = 1024;
    // byte range follows from the line count
    localparam int MEM_SIZE_IN_BYTES = MEM_64BIT_LINES * (LINE_W / 8);
    localparam int LINE_IDX_W        = 10;

    // tags 1..7, tag 0 is none / refused
    localparam int NUM_MEM_TAGS          = 7;
    localparam int TAG_W                 = 3;
    localparam int MEM_LATENCY_IN_CYCLES = 10;
    // wide enough to hold the latency
    localparam int CNT_W                 = 4;

    ////////////////////////////////////////////////////////////////////////////
    // types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [TAG_W-1:0]  mem_tag_t;
    typedef logic [LINE_W-1:0] mem_line_t;

    typedef enum logic [1:0] {
        BUS_NONE  = 2'd0,
        BUS_LOAD  = 2'd1,
        BUS_STORE = 2'd2
    } bus_cmd_e;

    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_e;

    // request from the requester, store data in the low lanes
    typedef struct packed {
        bus_cmd_e        cmd;
        logic [XLEN-1:0] addr;
        mem_size_e       size;
        mem_line_t       data;
    } mem_req_t;

    // load return, tag 0 means nothing on the bus
    typedef struct packed {
        mem_tag_t  tag;
        mem_line_t data;
    } mem_ret_t;

endpackage

`default_nettype wire

// File: mem_array.sv
/*
 * line storage for the data memory
 * combinational read, write at the clock edge
 */

`timescale 1ns/1ps
`default_nettype none

module mem_array (
    input  wire logic                              clk,
    input  wire logic [mem_pkg::LINE_IDX_W-1:0]    rd_idx,
    output mem_pkg::mem_line_t                     rd_line,
    input  wire logic                              wr_en,
    input  mem_pkg::mem_line_t                     wr_line
);

    // 64-bit lines, contents undefined until written
    mem_pkg::mem_line_t mem_q [mem_pkg::MEM_64BIT_LINES];

    // read port feeds the aligner directly
    assign rd_line = mem_q[rd_idx];

    // one address for read and write
    // store merge is built from rd_line of the same index
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_q[rd_idx] <= wr_line;
        end
    end

endmodule

`default_nettype wire

// File: mem_lane_align.sv
/*
 * request legality (range and alignment)
 * lane extraction for loads, zero extended
 * lane merge for stores
 */

`timescale 1ns/1ps
`default_nettype none

module mem_lane_align (
    input  mem_pkg::mem_req_t  req,
    input  mem_pkg::mem_line_t rd_line,
    output logic               legal,
    output mem_pkg::mem_line_t load_data,
    output mem_pkg::mem_line_t merged_line
);

    logic       in_range;
    logic       aligned;
    // bit offset of the addressed lane inside the line
    logic [5:0] bit_off;

    assign bit_off = {req.addr[2:0], 3'b000};

    ////////////////////////////////////////////////////////////////////////////
    // legality
    ////////////////////////////////////////////////////////////////////////////

    assign in_range = (req.addr < mem_pkg::MEM_SIZE_IN_BYTES);

    always_comb begin
        unique case (req.size)
            mem_pkg::BYTE:   aligned = 1'b1;
            mem_pkg::HALF:   aligned = (req.addr[0] == 1'b0);
            mem_pkg::WORD:   aligned = (req.addr[1:0] == 2'b00);
            mem_pkg::DOUBLE: aligned = (req.addr[2:0] == 3'b000);
            default:         aligned = 1'b0;
        endcase
    end

    // command is not looked at here, the tag pool gates on it
    assign legal = in_range && aligned;

    ////////////////////////////////////////////////////////////////////////////
    // load lanes and store merge
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        // upper bits stay zero
        load_data = '0;
        unique case (req.size)
            mem_pkg::BYTE:   load_data[7:0]  = rd_line[bit_off +: 8];
            mem_pkg::HALF:   load_data[15:0] = rd_line[bit_off +: 16];
            mem_pkg::WORD:   load_data[31:0] = rd_line[bit_off +: 32];
            default:         load_data       = rd_line;
        endcase
    end

    always_comb begin
        // untouched lanes keep the old line
        merged_line = rd_line;
        unique case (req.size)
            mem_pkg::BYTE:   merged_line[bit_off +: 8]  = req.data[7:0];
            mem_pkg::HALF:   merged_line[bit_off +: 16] = req.data[15:0];
            mem_pkg::WORD:   merged_line[bit_off +: 32] = req.data[31:0];
            default:         merged_line                = req.data;
        endcase
    end

endmodule

`default_nettype wire

// File: mem_tag_pool.sv
/*
 * tag allocation and per-tag latency countdown
 * holds load data until its return slot
 * registered response tag and single load return per cycle
 */

`timescale 1ns/1ps
`default_nettype none

module mem_tag_pool (
    input  wire logic          clk,
    input  wire logic          rst_n,
    input  mem_pkg::bus_cmd_e  cmd,
    input  wire logic          legal,
    input  mem_pkg::mem_line_t load_data,
    output logic               wr_en,
    output mem_pkg::mem_tag_t  rsp_tag,
    output mem_pkg::mem_ret_t  ret
);

    // per tag state, index 0 unused (tag 0 means none)
    logic [mem_pkg::CNT_W-1:0]    cnt_q  [1:mem_pkg::NUM_MEM_TAGS];
    logic [mem_pkg::NUM_MEM_TAGS:1] wait_q;
    mem_pkg::mem_line_t           held_q [1:mem_pkg::NUM_MEM_TAGS];

    mem_pkg::mem_tag_t  free_tag;
    mem_pkg::mem_tag_t  ret_sel;
    logic               grant;
    logic               is_load;
    mem_pkg::mem_tag_t  rsp_q;
    mem_pkg::mem_tag_t  ret_tag_q;
    mem_pkg::mem_line_t ret_data_q;

    ////////////////////////////////////////////////////////////////////////////
    // selection
    ////////////////////////////////////////////////////////////////////////////

    // lowest free tag, walk downward so the lowest wins
    always_comb begin
        free_tag = '0;
        for (int t = mem_pkg::NUM_MEM_TAGS; t >= 1; t--) begin
            if (cnt_q[t] == '0 && !wait_q[t]) begin
                free_tag = mem_pkg::mem_tag_t'(t);
            end
        end
    end

    // load due when its count reaches zero at this edge
    // a load still waiting at zero is also due (lowest tag first)
    always_comb begin
        ret_sel = '0;
        for (int t = mem_pkg::NUM_MEM_TAGS; t >= 1; t--) begin
            if (wait_q[t] && cnt_q[t] <= mem_pkg::CNT_W'(1)) begin
                ret_sel = mem_pkg::mem_tag_t'(t);
            end
        end
    end

    assign is_load = (cmd == mem_pkg::BUS_LOAD);
    assign grant   = (cmd != mem_pkg::BUS_NONE) && legal && (free_tag != '0);
    // store lands in the array at the granting edge
    assign wr_en   = grant && (cmd == mem_pkg::BUS_STORE);

    ////////////////////////////////////////////////////////////////////////////
    // control state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int t = 1; t <= mem_pkg::NUM_MEM_TAGS; t++) begin
                cnt_q[t] <= '0;
            end
            wait_q    <= '0;
            rsp_q     <= '0;
            ret_tag_q <= '0;
        end else begin
            for (int t = 1; t <= mem_pkg::NUM_MEM_TAGS; t++) begin
                if (cnt_q[t] != '0) begin
                    cnt_q[t] <= cnt_q[t] - 1'b1;
                end
            end
            if (ret_sel != '0) begin
                wait_q[ret_sel] <= 1'b0;
            end
            // granted tag is free, so never the one being returned
            if (grant) begin
                cnt_q[free_tag]  <= mem_pkg::CNT_W'(mem_pkg::MEM_LATENCY_IN_CYCLES);
                wait_q[free_tag] <= is_load;
            end
            rsp_q     <= grant ? free_tag : '0;
            ret_tag_q <= ret_sel;
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (grant && is_load) begin
            held_q[free_tag] <= load_data;
        end
        if (ret_sel != '0) begin
            ret_data_q <= held_q[ret_sel];
        end
    end

    assign rsp_tag  = rsp_q;
    assign ret.tag  = ret_tag_q;
    assign ret.data = ret_data_q;

endmodule

`default_nettype wire

// File: supermem.sv
/*
 * single-port tagged memory, fixed latency
 * array, lane aligner and tag pool
 */

`timescale 1ns/1ps
`default_nettype none

module supermem (
    input  wire logic         clk,
    input  wire logic         rst_n,
    input  mem_pkg::mem_req_t req,
    output mem_pkg::mem_tag_t rsp_tag,
    output mem_pkg::mem_ret_t ret
);

    logic [mem_pkg::LINE_IDX_W-1:0] line_idx;
    mem_pkg::mem_line_t             rd_line;
    mem_pkg::mem_line_t             merged_line;
    mem_pkg::mem_line_t             load_data;
    logic                           legal;
    logic                           wr_en;

    // line address sits above the 3-bit byte offset
    assign line_idx = req.addr[mem_pkg::LINE_IDX_W+2:3];

    mem_array mem_array_i (
        .clk     (clk),
        .rd_idx  (line_idx),
        .rd_line (rd_line),
        .wr_en   (wr_en),
        .wr_line (merged_line)
    );

    // checks and lane handling on the line just read
    mem_lane_align mem_lane_align_i (
        .req         (req),
        .rd_line     (rd_line),
        .legal       (legal),
        .load_data   (load_data),
        .merged_line (merged_line)
    );

    // grant decision, latency and return
    mem_tag_pool mem_tag_pool_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd       (req.cmd),
        .legal     (legal),
        .load_data (load_data),
        .wr_en     (wr_en),
        .rsp_tag   (rsp_tag),
        .ret       (ret)
    );

endmodule

`default_nettype wire

// File: supermem_checker.sv
/*
 * concurrent assertions on the tagged memory
 * refusal of bad requests, load latency, reset values, tag uniqueness
 */

`timescale 1ns/1ps
`default_nettype none

module supermem_checker (
    input wire logic          clk,
    input wire logic          rst_n,
    input mem_pkg::mem_req_t  req,
    input mem_pkg::mem_tag_t  rsp_tag,
    input mem_pkg::mem_ret_t  ret
);

    // failed assertions, read by the testbench at the end
    int err_cnt = 0;

    logic                      bad_req;
    logic [2:0]                low_mask;
    logic [mem_pkg::CNT_W-1:0] busy_q [1:mem_pkg::NUM_MEM_TAGS];

    // low address bits that must be clear for the access size
    assign low_mask = 3'((4'd1 << req.size) - 4'd1);
    assign bad_req  = (req.cmd != mem_pkg::BUS_NONE)
                   && ((req.addr >= mem_pkg::MEM_SIZE_IN_BYTES)
                   || ((req.addr[2:0] & low_mask) != 3'b000));

    // shadow of tag occupancy, seen from rsp_tag
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int t = 1; t <= mem_pkg::NUM_MEM_TAGS; t++) begin
                busy_q[t] <= '0;
            end
        end else begin
            for (int t = 1; t <= mem_pkg::NUM_MEM_TAGS; t++) begin
                if (busy_q[t] != '0) begin
                    busy_q[t] <= busy_q[t] - 1'b1;
                end
            end
            if (rsp_tag != '0) begin
                busy_q[rsp_tag] <= mem_pkg::CNT_W'(mem_pkg::MEM_LATENCY_IN_CYCLES);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // properties
    ////////////////////////////////////////////////////////////////////////////

    refuse_bad: assert property (@(posedge clk) disable iff (!rst_n)
        bad_req |=> (rsp_tag == '0))
    else begin
        err_cnt++;
        $error("out of range or misaligned request was granted");
    end

    // load return lands exactly one latency after the response
    load_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_tag != '0 && $past(req.cmd) == mem_pkg::BUS_LOAD)
        |-> ##(mem_pkg::MEM_LATENCY_IN_CYCLES)
        (ret.tag == $past(rsp_tag, mem_pkg::MEM_LATENCY_IN_CYCLES)))
    else begin
        err_cnt++;
        $error("load return missing or late");
    end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> (rsp_tag == '0 && ret.tag == '0))
    else begin
        err_cnt++;
        $error("tag outputs not zero during reset");
    end

    tag_unique: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_tag != '0) |-> (busy_q[rsp_tag] == '0))
    else begin
        err_cnt++;
        $error("tag granted while still outstanding");
    end

endmodule

`default_nettype wire

// File: tb_clkgen.sv
/*
 * testbench clock, 8 ns period
 * reset held low for the first 4 rising edges
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // release on the 4th edge, after the DUT has sampled it low
    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: supermem_tb.sv
/*
 * testbench for the tagged memory
 * line-array reference model, directed and random stimulus
 * one result line per test, counts at the end
 */

`timescale 1ns/1ps
`default_nettype none

module supermem_tb;

    logic               clk;
    logic               rst_n;
    mem_pkg::mem_req_t  req;
    mem_pkg::mem_tag_t  rsp_tag;
    mem_pkg::mem_ret_t  ret;
    // reference copy of the array
    mem_pkg::mem_line_t model [mem_pkg::MEM_64BIT_LINES];
    string              cur_test = "setup";
    int                 test_errs;
    int                 tests_run;
    int                 tests_failed;

    tb_clkgen tb_clkgen_i (.clk(clk), .rst_n(rst_n));

    supermem supermem_i (
        .clk(clk), .rst_n(rst_n), .req(req), .rsp_tag(rsp_tag), .ret(ret)
    );

    bind supermem supermem_checker supermem_checker_i (
        .clk(clk), .rst_n(rst_n), .req(req), .rsp_tag(rsp_tag), .ret(ret)
    );

    ////////////////////////////////////////////////////////////////////////////
    // reference model and checks
    ////////////////////////////////////////////////////////////////////////////

    // byte by byte, store data taken from the low bytes
    function automatic void model_store(input logic [31:0] addr,
                                        input mem_pkg::mem_size_e size,
                                        input mem_pkg::mem_line_t data);
        for (int i = 0; i < (1 << size); i++) begin
            model[addr >> 3][(addr[2:0] + i) * 8 +: 8] = data[i * 8 +: 8];
        end
    endfunction

    function automatic mem_pkg::mem_line_t model_load(input logic [31:0] addr,
                                                      input mem_pkg::mem_size_e size);
        mem_pkg::mem_line_t val;
        val = '0;
        for (int i = 0; i < (1 << size); i++) begin
            val[i * 8 +: 8] = model[addr >> 3][(addr[2:0] + i) * 8 +: 8];
        end
        return val;
    endfunction

    function automatic logic [31:0] rand_line_addr();
        return 32'($urandom_range(mem_pkg::MEM_64BIT_LINES - 1)) << 3;
    endfunction

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("[FAIL] %s %s expected %0h actual %0h", cur_test, what, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_true(input logic cond, input string why);
        assert (cond) else begin
            $display("[ERROR] %s: %s", cur_test, why);
            test_errs++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("[ERROR] %s: %s", cur_test, why);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        $display("%-12s %s, %0d failed checks", cur_test,
                 (test_errs == 0) ? "passed" : "failed", test_errs);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus tasks
    ////////////////////////////////////////////////////////////////////////////

    // one request for one cycle, tag read in the cycle after sampling
    task automatic issue(input mem_pkg::bus_cmd_e op, input logic [31:0] addr,
                         input mem_pkg::mem_size_e size, input mem_pkg::mem_line_t data,
                         output mem_pkg::mem_tag_t tag);
        @(posedge clk);
        req <= '{cmd: op, addr: addr, size: size, data: data};
        @(posedge clk);
        req <= '0;
        @(negedge clk);
        tag = rsp_tag;
    endtask

    task automatic store(input logic [31:0] addr, input mem_pkg::mem_size_e size,
                         input mem_pkg::mem_line_t data);
        mem_pkg::mem_tag_t tag;
        issue(mem_pkg::BUS_STORE, addr, size, data, tag);
        check_true(tag != '0, "store was refused");
        if (tag != '0) begin
            model_store(addr, size, data);
        end
    endtask

    task automatic load_check(input logic [31:0] addr, input mem_pkg::mem_size_e size,
                              input string what);
        mem_pkg::mem_tag_t tag;
        int                cycles;
        issue(mem_pkg::BUS_LOAD, addr, size, '0, tag);
        check_true(tag != '0, "load was refused");
        if (tag != '0) begin
            cycles = 0;
            do begin
                @(negedge clk);
                cycles++;
                if (cycles > 2 * mem_pkg::MEM_LATENCY_IN_CYCLES) begin
                    abort_run($sformatf("no return for tag %0d", tag));
                end
            end while (ret.tag != tag);
            check_val({what, " latency"}, mem_pkg::MEM_LATENCY_IN_CYCLES, cycles);
            check_val(what, model_load(addr, size), ret.data);
        end
    endtask

    task automatic expect_refused(input mem_pkg::bus_cmd_e op, input logic [31:0] addr,
                                  input mem_pkg::mem_size_e size, input string what);
        mem_pkg::mem_tag_t tag;
        issue(op, addr, size, {$urandom, $urandom}, tag);
        check_val(what, 0, tag);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic [31:0]       base;
        logic [31:0]       addrs [8];
        mem_pkg::mem_tag_t tags [8];
        logic [7:0]        returned;
        logic              asked;
        logic              ask_now;
        int                hit;
        int                done;
        int                chk_errs;

        req = '0;
        void'($urandom(32'ha0c8_1bfd));
        for (int c = 0; rst_n !== 1'b1; c++) begin
            if (c > 16) begin
                abort_run("reset was never released");
            end
            @(posedge clk);
        end

        begin_test("reset_idle");
        for (int c = 0; c < 12; c++) begin
            @(negedge clk);
            check_val("rsp_tag", 0, rsp_tag);
            check_val("ret.tag", 0, ret.tag);
        end
        end_test();

        begin_test("double");
        for (int n = 0; n < 3; n++) begin
            base = rand_line_addr();
            store(base, mem_pkg::DOUBLE, {$urandom, $urandom});
            load_check(base, mem_pkg::DOUBLE, "double load");
        end
        end_test();

        // partial stores over one line, then every lane read back
        begin_test("sized");
        base = rand_line_addr();
        store(base, mem_pkg::DOUBLE, {$urandom, $urandom});
        store(base + 5, mem_pkg::BYTE, {$urandom, $urandom});
        store(base + 2, mem_pkg::HALF, {$urandom, $urandom});
        store(base + 4, mem_pkg::WORD, {$urandom, $urandom});
        store(base + 7, mem_pkg::BYTE, {$urandom, $urandom});
        for (int s = 0; s < 4; s++) begin
            for (int o = 0; o < 8; o += (1 << s)) begin
                load_check(base + o, mem_pkg::mem_size_e'(s),
                           $sformatf("size %0d offset %0d", s, o));
            end
        end
        end_test();

        begin_test("reject");
        expect_refused(mem_pkg::BUS_STORE, base + 1, mem_pkg::HALF, "misaligned half");
        expect_refused(mem_pkg::BUS_STORE, base + 2, mem_pkg::WORD, "misaligned word");
        expect_refused(mem_pkg::BUS_STORE, base + 4, mem_pkg::DOUBLE, "misaligned double");
        expect_refused(mem_pkg::BUS_LOAD, base + 3, mem_pkg::WORD, "misaligned load");
        expect_refused(mem_pkg::BUS_STORE, mem_pkg::MEM_SIZE_IN_BYTES, mem_pkg::BYTE,
                       "store at range end");
        expect_refused(mem_pkg::BUS_LOAD, 32'hffff_fff8, mem_pkg::DOUBLE, "load far out");
        load_check(base, mem_pkg::DOUBLE, "line after refusals");
        end_test();

        begin_test("tag_exhaust");
        for (int k = 0; k < 8; k++) begin
            addrs[k] = rand_line_addr();
            store(addrs[k], mem_pkg::DOUBLE, {$urandom, $urandom});
        end
        // let every store tag drain
        repeat (mem_pkg::MEM_LATENCY_IN_CYCLES + 2) @(posedge clk);
        // eight back to back loads, tag of load k-1 read in cycle k
        for (int k = 0; k <= 8; k++) begin
            @(posedge clk);
            if (k < 8) begin
                req <= '{cmd: mem_pkg::BUS_LOAD, addr: addrs[k], size: mem_pkg::DOUBLE,
                         data: '0};
            end else begin
                req <= '0;
            end
            @(negedge clk);
            if (k > 0) begin
                tags[k - 1] = rsp_tag;
            end
        end
        check_val("eighth load tag", 0, tags[7]);
        for (int k = 0; k < 7; k++) begin
            check_true(tags[k] != '0, "load refused while tags were free");
            for (int j = 0; j < k; j++) begin
                check_true(tags[j] != tags[k], "same tag granted twice");
            end
        end
        // retry every other cycle while collecting returns
        returned = '0;
        asked    = 1'b0;
        done     = 0;
        for (int c = 0; done < 8; c++) begin
            if (c > 4 * mem_pkg::MEM_LATENCY_IN_CYCLES) begin
                abort_run("returns or retry never completed");
            end
            @(posedge clk);
            ask_now = (tags[7] == '0) && !asked;
            if (ask_now) begin
                req <= '{cmd: mem_pkg::BUS_LOAD, addr: addrs[7], size: mem_pkg::DOUBLE,
                         data: '0};
            end else begin
                req <= '0;
            end
            @(negedge clk);
            if (asked && rsp_tag != '0) begin
                tags[7] = rsp_tag;
            end
            asked = ask_now;
            if (ret.tag != '0) begin
                hit = -1;
                for (int k = 7; k >= 0; k--) begin
                    if (!returned[k] && tags[k] == ret.tag) begin
                        hit = k;
                    end
                end
                check_true(hit >= 0, "return carries a tag with no load outstanding");
                if (hit >= 0) begin
                    returned[hit] = 1'b1;
                    done++;
                    check_val($sformatf("return of load %0d", hit),
                              model_load(addrs[hit], mem_pkg::DOUBLE), ret.data);
                end
            end
        end
        end_test();

        repeat (mem_pkg::MEM_LATENCY_IN_CYCLES + 2) @(posedge clk);
        chk_errs = supermem_i.supermem_checker_i.err_cnt;
        $display("tests run %0d, tests failed %0d, assertion failures %0d",
                 tests_run, tests_failed, chk_errs);
        if (tests_failed == 0 && chk_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
mem_pkg.sv
mem_array.sv
mem_lane_align.sv
mem_tag_pool.sv
supermem.sv
supermem_checker.sv
tb_clkgen.sv
supermem_tb.sv
